// ==== verilog/dcache_pkg.sv ====
//==========================================================================
// L1 data cache package: cache geometry and the shared payload types
//==========================================================================
`default_nettype none

package dcache_pkg;

   // Word and address geometry
   localparam int DATA_W    = 64;                // One cache line holds one word
   localparam int BE_W      = DATA_W / 8;        // Byte enables per word
   localparam int ADDR_W    = 32;                // Byte address
   localparam int OFFSET_W  = $clog2(BE_W);      // Byte inside the word

   // Line geometry
   localparam int NUM_LINES = 256;
   localparam int INDEX_W   = $clog2(NUM_LINES);
   localparam int TAG_W     = ADDR_W - INDEX_W - OFFSET_W;  // Remaining upper bits

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [BE_W-1:0]    be_t;
   typedef logic [INDEX_W-1:0] index_t;
   typedef logic [TAG_W-1:0]   tag_t;

endpackage : dcache_pkg

`default_nettype wire

// ==== verilog/sram_port_if.sv ====
//==========================================================================
// Single-port array access bundle, one read or write per cycle
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

interface sram_port_if
   import dcache_pkg::*;
#(
   parameter type payload_t = data_t     // Word stored in the array
);

   // One enable per eight-bit slice, last slice may be partial
   localparam int SLICES = ($bits(payload_t) + 7) / 8;

   logic              req;               // Access strobe
   logic              we;                // Write when high, read otherwise
   index_t            addr;              // Line index
   payload_t          wdata;
   logic [SLICES-1:0] be;
   payload_t          rdata;             // Valid the cycle after a read, held until next read

   // Cache controller side
   modport controller (output req, we, addr, wdata, be, input rdata);

   // Storage side
   modport array (input req, we, addr, wdata, be, output rdata);

endinterface : sram_port_if

`default_nettype wire

// ==== verilog/sram.sv ====
//==========================================================================
// Single-port synchronous array with byte enables and one-cycle read
// latency, for any payload width
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module sram
   import dcache_pkg::*;
#(
   parameter type payload_t = data_t,
   parameter int  NUM_WORDS = NUM_LINES
)(
   input  logic       clk_i,
   input  logic       reset_i,
   sram_port_if.array port
);

   localparam int W      = $bits(payload_t);
   localparam int SLICES = (W + 7) / 8;      // Eight-bit slices per word

   payload_t mem_q [NUM_WORDS];              // Storage, contents survive reset

   // Byte-masked write
   always_ff @(posedge clk_i) begin
      if (port.req && port.we) begin
         for (int s = 0; s < SLICES; s++) begin
            if (port.be[s]) begin
               for (int k = 0; k < 8; k++) begin
                  // Top slice may be narrower than eight bits
                  if (8 * s + k < W) begin
                     mem_q[port.addr][8*s+k] <= port.wdata[8*s+k];
                  end
               end
            end
         end
      end
   end

   // Registered read port, keeps last word between reads
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         port.rdata <= '0;
      end else if (port.req && !port.we) begin
         port.rdata <= mem_q[port.addr];
      end
   end

endmodule : sram

`default_nettype wire

// ==== verilog/tag_check.sv ====
//==========================================================================
// Per-line valid bits with flush, and tag compare giving the hit signal
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module tag_check
   import dcache_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,
   input  index_t line_index_i,       // Registered index of the current lookup
   input  tag_t   lookup_tag_i,       // Tag of the request being looked up
   input  tag_t   stored_tag_i,       // Tag array read data
   input  logic   set_valid_i,        // Refill done for line_index_i
   input  logic   flush_i,            // Invalidate all lines
   output logic   hit_o
);

   logic [NUM_LINES-1:0] valid_q;     // One bit per line
   logic                 line_valid;
   logic                 tag_match;

   // Flush wins over a refill in the same cycle
   always_ff @(posedge clk_i) begin
      if (reset_i || flush_i) begin
         valid_q <= '0;
      end else if (set_valid_i) begin
         valid_q[line_index_i] <= 1'b1;
      end
   end

   assign line_valid = valid_q[line_index_i];

   // Stored tag is only meaningful for a valid line
   assign tag_match = (stored_tag_i == lookup_tag_i);

   assign hit_o = line_valid && tag_match;    // Settles the cycle after the array read

endmodule : tag_check

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
//==========================================================================
// Cache controller: lookup, write-through, miss refill and flush, drives
// the data and tag array ports and the memory port
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl
   import dcache_pkg::*;
(
   input  logic   clk_i,
   input  logic   reset_i,
   input  logic   req_i,
   input  logic   we_i,
   input  logic   flush_i,
   input  addr_t  addr_i,
   input  data_t  wdata_i,
   input  be_t    be_i,
   input  logic   hit_i,              // From tag_check, valid in lookup cycle
   input  logic   mem_rvalid_i,
   input  data_t  mem_rdata_i,
   sram_port_if.controller data_port,
   sram_port_if.controller tag_port,
   output tag_t   lookup_tag_o,
   output index_t line_index_o,
   output logic   set_valid_o,
   output logic   flush_o,
   output data_t  rdata_o,
   output logic   rvalid_o,
   output logic   busy_o,
   output logic   mem_req_o,
   output logic   mem_we_o,
   output addr_t  mem_addr_o,
   output data_t  mem_wdata_o,
   output be_t    mem_be_o
);

   typedef enum logic [1:0] {
      S_IDLE,                         // Accepting requests, lookup of previous one
      S_WRITE,                        // Memory write strobe, data array update on hit
      S_REFILL_WAIT,                  // Waiting for memory read data
      S_REFILL_FILL                   // Writing refilled line into both arrays
   } state_e;

   state_e state_q, state_d;

   logic   lookup_q;                  // Arrays hold data for the registered request
   logic   we_q;
   addr_t  addr_q;
   data_t  wdata_q;
   be_t    be_q;

   logic   req_accept;
   logic   read_hit;
   logic   refill_done;
   index_t req_index;                 // Index of the incoming request

   assign req_index = addr_i[OFFSET_W +: INDEX_W];

   // Split registered address for the lookup
   assign line_index_o = addr_q[OFFSET_W +: INDEX_W];
   assign lookup_tag_o = addr_q[ADDR_W-1 -: TAG_W];

   // Busy while a write or a read miss is in flight, miss seen combinationally
   assign busy_o = (state_q != S_IDLE) || (lookup_q && (we_q || !hit_i));

   assign req_accept  = req_i && !busy_o;
   assign flush_o     = flush_i && !busy_o;   // Clears valid bits at next edge
   assign read_hit    = lookup_q && !we_q && hit_i;
   assign refill_done = (state_q == S_REFILL_WAIT) && mem_rvalid_i;
   assign set_valid_o = (state_q == S_REFILL_FILL);

   // Memory port fields come straight from the held request
   assign mem_we_o    = we_q;
   assign mem_addr_o  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};  // Word aligned
   assign mem_wdata_o = wdata_q;
   assign mem_be_o    = be_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (lookup_q && we_q) begin
               state_d = S_WRITE;     // Stores always go to memory
            end else if (lookup_q && !hit_i) begin
               state_d = S_REFILL_WAIT;
            end
         end
         S_WRITE:       state_d = S_IDLE;
         S_REFILL_WAIT: if (mem_rvalid_i) state_d = S_REFILL_FILL;
         S_REFILL_FILL: state_d = S_IDLE;
         default:       state_d = S_IDLE;
      endcase
   end

   // Array port steering
   always_comb begin
      data_port.req   = 1'b0;
      data_port.we    = 1'b0;
      data_port.addr  = req_index;
      data_port.wdata = wdata_q;
      data_port.be    = be_q;
      tag_port.req    = 1'b0;
      tag_port.we     = 1'b0;
      tag_port.addr   = req_index;
      tag_port.wdata  = lookup_tag_o;
      tag_port.be     = '1;           // Tags are always written whole

      if (state_q == S_WRITE) begin
         data_port.req  = hit_i;      // No allocate on a write miss
         data_port.we   = 1'b1;
         data_port.addr = line_index_o;
      end else if (state_q == S_REFILL_FILL) begin
         data_port.req   = 1'b1;
         data_port.we    = 1'b1;
         data_port.addr  = line_index_o;
         data_port.wdata = rdata_o;   // Still holds the memory word
         data_port.be    = '1;
         tag_port.req    = 1'b1;
         tag_port.we     = 1'b1;
         tag_port.addr   = line_index_o;
      end else if (req_accept) begin
         data_port.req = !we_i;       // Stores only need the tag
         tag_port.req  = 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q   <= S_IDLE;
         lookup_q  <= 1'b0;
         rvalid_o  <= 1'b0;
         mem_req_o <= 1'b0;
      end else begin
         state_q   <= state_d;
         lookup_q  <= req_accept;
         rvalid_o  <= read_hit || refill_done;
         mem_req_o <= (state_q == S_IDLE) && (state_d != S_IDLE);  // One-cycle strobe
      end
   end

   // Request and read data holding registers
   always_ff @(posedge clk_i) begin
      if (req_accept) begin
         addr_q  <= addr_i;
         we_q    <= we_i;
         wdata_q <= wdata_i;
         be_q    <= be_i;
      end
      if (read_hit) begin
         rdata_o <= data_port.rdata;
      end else if (refill_done) begin
         rdata_o <= mem_rdata_i;
      end
   end

endmodule : dcache_ctrl

`default_nettype wire

// ==== verilog/dcache.sv ====
//==========================================================================
// Direct-mapped write-through L1 data cache, 256 lines of one 64-bit word
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module dcache
   import dcache_pkg::*;
(
   input  logic  clk_i,
   input  logic  reset_i,
   // Core side
   input  logic  req_i,
   input  logic  we_i,
   input  addr_t addr_i,
   input  data_t wdata_i,
   input  be_t   be_i,
   input  logic  flush_i,
   output data_t rdata_o,
   output logic  rvalid_o,
   output logic  busy_o,
   // Memory side
   output logic  mem_req_o,
   output logic  mem_we_o,
   output addr_t mem_addr_o,
   output data_t mem_wdata_o,
   output be_t   mem_be_o,
   input  logic  mem_rvalid_i,
   input  data_t mem_rdata_i
);

   logic   hit;
   tag_t   lookup_tag;
   index_t line_index;
   logic   set_valid;
   logic   flush;

   sram_port_if #(.payload_t(data_t)) data_port ();
   sram_port_if #(.payload_t(tag_t))  tag_port ();

   dcache_ctrl ctrl_inst (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .req_i        (req_i),
      .we_i         (we_i),
      .flush_i      (flush_i),
      .addr_i       (addr_i),
      .wdata_i      (wdata_i),
      .be_i         (be_i),
      .hit_i        (hit),
      .mem_rvalid_i (mem_rvalid_i),
      .mem_rdata_i  (mem_rdata_i),
      .data_port    (data_port.controller),
      .tag_port     (tag_port.controller),
      .lookup_tag_o (lookup_tag),
      .line_index_o (line_index),
      .set_valid_o  (set_valid),
      .flush_o      (flush),
      .rdata_o      (rdata_o),
      .rvalid_o     (rvalid_o),
      .busy_o       (busy_o),
      .mem_req_o    (mem_req_o),
      .mem_we_o     (mem_we_o),
      .mem_addr_o   (mem_addr_o),
      .mem_wdata_o  (mem_wdata_o),
      .mem_be_o     (mem_be_o)
   );

   sram #(.payload_t(data_t), .NUM_WORDS(NUM_LINES)) data_array (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .port    (data_port.array)
   );

   sram #(.payload_t(tag_t), .NUM_WORDS(NUM_LINES)) tag_array (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .port    (tag_port.array)
   );

   tag_check tag_check_inst (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .line_index_i (line_index),
      .lookup_tag_i (lookup_tag),
      .stored_tag_i (tag_port.rdata),    // Tag array output feeds the compare
      .set_valid_i  (set_valid),
      .flush_i      (flush),
      .hit_o        (hit)
   );

endmodule : dcache

`default_nettype wire

// ==== test/mem_model.sv ====
//==========================================================================
// Backing memory model with random read latency, also the reference
// for expected read data
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module mem_model
   import dcache_pkg::*;
#(
   parameter int MAX_LATENCY = 6
)(
   input  logic  clk_i,
   input  logic  reset_i,
   input  logic  mem_req_i,
   input  logic  mem_we_i,
   input  addr_t mem_addr_i,
   input  data_t mem_wdata_i,
   input  be_t   mem_be_i,
   output logic  mem_rvalid_o,
   output data_t mem_rdata_o
);

   data_t  words [addr_t];            // Only written words, rest use the fill pattern
   integer seed = 2537;
   int     wait_cnt;
   logic   pending;                   // One read outstanding at most
   addr_t  pend_addr;

   function automatic addr_t align_word(input addr_t a);
      return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
   endfunction

   // Every word address gets its own initial value
   function automatic data_t fill_word(input addr_t a);
      return {a ^ 32'h5a3c_96e1, ~a + 32'h1357_9bdf};
   endfunction

   function automatic data_t read_word(input addr_t a);
      if (words.exists(align_word(a))) begin
         return words[align_word(a)];
      end
      return fill_word(align_word(a));
   endfunction

   function automatic data_t apply_byte_enables(input data_t old, input data_t wdata,
                                                input be_t be);
      data_t res;
      res = old;
      for (int b = 0; b < BE_W; b++) begin
         if (be[b]) res[8*b +: 8] = wdata[8*b +: 8];
      end
      return res;
   endfunction

   always @(posedge clk_i) begin
      if (reset_i) begin
         pending      <= 1'b0;
         mem_rvalid_o <= 1'b0;
         mem_rdata_o  <= '0;
      end else begin
         mem_rvalid_o <= 1'b0;
         if (mem_req_i && mem_we_i) begin
            // Writes land at once
            words[align_word(mem_addr_i)] =
               apply_byte_enables(read_word(mem_addr_i), mem_wdata_i, mem_be_i);
         end else if (mem_req_i) begin
            pending   <= 1'b1;
            pend_addr <= mem_addr_i;
            wait_cnt  <= 1 + $unsigned($random(seed)) % MAX_LATENCY;   // 1 to 6 cycles
         end
         if (pending) begin
            if (wait_cnt <= 1) begin
               mem_rvalid_o <= 1'b1;
               mem_rdata_o  <= read_word(pend_addr);
               pending      <= 1'b0;
            end else begin
               wait_cnt <= wait_cnt - 1;
            end
         end
      end
   end

endmodule : mem_model

`default_nettype wire

// ==== test/tb_dcache.sv ====
//==========================================================================
// Testbench for the write-through L1 data cache, directed and random
// traffic against the backing memory model
//==========================================================================
`timescale 1ns/1ns
`default_nettype none

module tb_dcache
   import dcache_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 50;
   localparam int RANDOM_OPS     = 60;

   logic  clk_i, reset_i, req_i, we_i, flush_i;
   addr_t addr_i;
   data_t wdata_i;
   be_t   be_i;
   data_t rdata_o;
   logic  rvalid_o, busy_o;
   logic  mem_req_o, mem_we_o, mem_rvalid_i;
   addr_t mem_addr_o;
   data_t mem_wdata_o, mem_rdata_i;
   be_t   mem_be_o;

   integer rand_seed = 2537;
   int     cycle_cnt = 0;             // Rising edges seen so far
   int     mem_reads = 0;
   int     mem_writes = 0;
   int     mem_strobe_cycle, mem_rvalid_cycle;
   addr_t  last_mem_addr;
   data_t  last_mem_wdata;
   be_t    last_mem_be;
   logic   mem_req_prev = 1'b0;
   int     error_count = 0;
   int     test_start_errors = 0;
   int     tests_passed = 0;
   int     tests_failed = 0;
   logic   timed_out = 1'b0;
   tag_t   known_tag [index_t];       // Lines known valid, with their tags

   dcache dcache_inst (.*);

   mem_model mem_model_inst (
      .clk_i, .reset_i,
      .mem_req_i   (mem_req_o),    .mem_we_i    (mem_we_o),
      .mem_addr_i  (mem_addr_o),   .mem_wdata_i (mem_wdata_o),
      .mem_be_i    (mem_be_o),     .mem_rvalid_o(mem_rvalid_i),
      .mem_rdata_o (mem_rdata_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // Memory port monitor, sees values from before each edge
   always @(posedge clk_i) begin
      cycle_cnt    <= cycle_cnt + 1;
      mem_req_prev <= mem_req_o && !reset_i;
      if (!reset_i) begin
         if (mem_req_o) begin
            mem_strobe_cycle <= cycle_cnt;
            last_mem_addr    <= mem_addr_o;
            last_mem_wdata   <= mem_wdata_o;
            last_mem_be      <= mem_be_o;
            if (mem_we_o) mem_writes <= mem_writes + 1;
            else          mem_reads  <= mem_reads + 1;
         end
         if (mem_rvalid_i) mem_rvalid_cycle <= cycle_cnt;
         assert (!(mem_req_o && mem_req_prev)) else begin
            $display("Memory request strobe stayed high for two cycles at time %0t", $time);
            error_count++;
         end
      end
   end

   task automatic check_value(input string name, input data_t expected, input data_t actual);
      assert (actual === expected) else begin
         $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                  $time, name, expected, actual);
         error_count++;
      end
   endtask

   function automatic data_t ref_word(input addr_t a);
      return mem_model_inst.read_word(a);
   endfunction

   function automatic addr_t word_addr(input addr_t a);
      return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
   endfunction

   // Old bytes kept where be is clear
   function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
      data_t res;
      for (int b = 0; b < BE_W; b++) begin
         res[8*b +: 8] = be[b] ? wdata[8*b +: 8] : old[8*b +: 8];
      end
      return res;
   endfunction

   task automatic next_cycle();
      @(posedge clk_i);
      #10;                            // Drive and sample point
   endtask

   task automatic wait_idle();
      int waited;
      waited = 0;
      while (busy_o && waited < TIMEOUT_CYCLES) begin
         next_cycle();
         waited++;
      end
      if (busy_o) begin
         $display("Timeout at %0t: busy_o stayed high", $time);
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_rvalid(output data_t data, output int seen_cycle);
      int waited;
      waited = 0;
      while (!rvalid_o && waited < TIMEOUT_CYCLES) begin
         next_cycle();
         waited++;
      end
      if (!rvalid_o) begin
         $display("Timeout at %0t: no read data returned", $time);
         timed_out = 1'b1;
      end
      data       = rdata_o;
      seen_cycle = cycle_cnt;
   endtask

   task automatic issue_request(input logic we, input addr_t addr, input data_t wdata,
                                input be_t be, output int accept_cycle);
      wait_idle();                    // busy_o does not depend on req_i
      req_i   = 1'b1;
      we_i    = we;
      addr_i  = addr;
      wdata_i = wdata;
      be_i    = be;
      next_cycle();
      accept_cycle = cycle_cnt;
      req_i = 1'b0;
      we_i  = 1'b0;
   endtask

   // Hit or miss predicted from the known-valid lines
   task automatic check_read(input addr_t addr, output data_t data);
      index_t idx;
      tag_t   tag;
      logic   expect_hit;
      int     reads_before, accept_cycle, seen_cycle;
      idx          = addr[OFFSET_W +: INDEX_W];
      tag          = addr[ADDR_W-1 -: TAG_W];
      expect_hit   = known_tag.exists(idx) && (known_tag[idx] == tag);
      reads_before = mem_reads;
      issue_request(1'b0, addr, '0, '0, accept_cycle);
      wait_rvalid(data, seen_cycle);
      check_value("rdata_o", ref_word(addr), data);
      if (expect_hit) begin
         check_value("rvalid_o latency", 1, seen_cycle - accept_cycle);
         check_value("mem read strobes", reads_before, mem_reads);
      end else begin
         check_value("mem read strobes", reads_before + 1, mem_reads);
         check_value("mem_req_o cycle", accept_cycle + 1, mem_strobe_cycle);
         check_value("mem_addr_o", word_addr(addr), last_mem_addr);
         check_value("rvalid_o cycle", mem_rvalid_cycle + 1, seen_cycle);
         known_tag[idx] = tag;        // Refill makes the line valid
      end
      next_cycle();
      check_value("rvalid_o", 0, rvalid_o);   // Single pulse
   endtask

   task automatic do_write(input addr_t addr, input data_t wdata, input be_t be);
      int writes_before, accept_cycle;
      writes_before = mem_writes;
      issue_request(1'b1, addr, wdata, be, accept_cycle);
      wait_idle();
      check_value("busy_o fall cycle", accept_cycle + 2, cycle_cnt);
      check_value("mem write strobes", writes_before + 1, mem_writes);
      check_value("mem_req_o cycle", accept_cycle + 1, mem_strobe_cycle);
      check_value("mem_addr_o", word_addr(addr), last_mem_addr);
      check_value("mem_wdata_o", wdata, last_mem_wdata);
      check_value("mem_be_o", be, last_mem_be);
   endtask

   task automatic do_flush();
      wait_idle();
      flush_i = 1'b1;
      next_cycle();
      flush_i = 1'b0;
      check_value("busy_o", 0, busy_o);
      known_tag.delete();
   endtask

   // Second read accepted in the cycle the first one's lookup completes
   task automatic read_back_to_back(input addr_t a0, input addr_t a1);
      int reads_before;
      wait_idle();
      reads_before = mem_reads;
      req_i  = 1'b1;
      we_i   = 1'b0;
      addr_i = a0;
      next_cycle();
      check_value("busy_o", 0, busy_o);
      addr_i = a1;
      next_cycle();
      req_i = 1'b0;
      check_value("rvalid_o", 1, rvalid_o);
      check_value("rdata_o", ref_word(a0), rdata_o);
      next_cycle();
      check_value("rvalid_o", 1, rvalid_o);
      check_value("rdata_o", ref_word(a1), rdata_o);
      check_value("mem read strobes", reads_before, mem_reads);
      next_cycle();
      check_value("rvalid_o", 0, rvalid_o);
   endtask

   task automatic finish_test(input string name);
      if (error_count == test_start_errors && !timed_out) begin
         tests_passed++;
         $display("Test %s: ok", name);
      end else begin
         tests_failed++;
         $display("Test %s: FAILED, %0d errors", name, error_count - test_start_errors);
      end
      test_start_errors = error_count;
   endtask

   task automatic run_random_mix();
      int    op;
      addr_t addr;
      data_t data;
      for (int i = 0; i < RANDOM_OPS; i++) begin
         op   = $unsigned($random(rand_seed)) % 8;
         // Two tags over four lines, any byte offset
         addr = 32'h0001_0000 + (($unsigned($random(rand_seed)) % 2) << 11)
              + (($unsigned($random(rand_seed)) % 4) << 3) + $unsigned($random(rand_seed)) % 8;
         data = {$random(rand_seed), $random(rand_seed)};
         if (op == 0) do_flush();
         else if (op < 4) do_write(addr, data, be_t'($random(rand_seed)));
         else check_read(addr, data);
      end
   endtask

   initial begin
      addr_t a, b;
      data_t old_word, data;
      req_i   = 1'b0;
      we_i    = 1'b0;
      flush_i = 1'b0;
      addr_i  = '0;
      wdata_i = '0;
      be_i    = '0;
      reset_i = 1'b1;
      repeat (10) @(posedge clk_i);
      #10;
      reset_i = 1'b0;

      check_value("busy_o", 0, busy_o);
      check_value("rvalid_o", 0, rvalid_o);
      check_value("mem_req_o", 0, mem_req_o);
      check_read(32'h0000_1238, data);
      finish_test("reset and miss refill");

      check_read(32'h0000_1238, data);                    // Filled above
      check_read(32'h0000_2010, data);
      read_back_to_back(32'h0000_1238, 32'h0000_2010);
      finish_test("read hit");

      a        = 32'h0000_1238;
      old_word = ref_word(a);
      do_write(a, 64'hdead_beef_0bad_f00d, 8'b1010_0110);
      check_read(a, data);
      check_value("rdata_o merged", merge_bytes(old_word, 64'hdead_beef_0bad_f00d,
                  8'b1010_0110), data);
      finish_test("write-through with byte enables");

      a        = 32'h0004_5678;                           // Never read before
      old_word = ref_word(a);
      do_write(a, 64'h0123_4567_89ab_cdef, 8'h0f);
      check_read(a, data);
      check_value("rdata_o merged", merge_bytes(old_word, 64'h0123_4567_89ab_cdef,
                  8'h0f), data);
      finish_test("no write-allocate");

      a = 32'h0000_3040;
      b = a + 32'h0000_0800;                              // Same index, next tag
      check_read(a, data);
      check_read(b, data);
      check_read(a, data);
      check_read(b, data);
      check_read(b, data);
      do_flush();
      check_read(b, data);
      finish_test("conflict and flush");

      run_random_mix();
      finish_test("random mix");

      $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && error_count == 0 && !timed_out) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule : tb_dcache

`default_nettype wire

// ==== Bender.yml ====
package:
  name: dcache

dependencies: {}

sources:
  # Package and interface first, then the RTL in dependency order
  - files:
      - verilog/dcache_pkg.sv
      - verilog/sram_port_if.sv
      - verilog/sram.sv
      - verilog/tag_check.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache.sv

  # Simulation only
  - target: test
    files:
      - test/mem_model.sv
      - test/tb_dcache.sv

// ==== dcache.f ====
verilog/dcache_pkg.sv
verilog/sram_port_if.sv
verilog/sram.sv
verilog/tag_check.sv
verilog/dcache_ctrl.sv
verilog/dcache.sv
test/mem_model.sv
test/tb_dcache.sv
